/* hdl/chunk_settings.svh */
`ifndef CHUNK_SETTINGS_SVH
`define CHUNK_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// Chunk geometry
//////////////////////////////////////////////////////////////////////

// Dense bytes per chunk, also sparsemap width and nonzero depth
`define CHUNK_BYTES 32
// Nonzero bytes per write beat, one bus word
`define BUS_BYTES 4
`define BEAT_NUM (`CHUNK_BYTES / `BUS_BYTES)
// Sparsemap bits per group read
`define PREFIX_GROUP 8
`define GROUP_NUM (`CHUNK_BYTES / `PREFIX_GROUP)

//////////////////////////////////////////////////////////////////////
// Host register map and sink base
//////////////////////////////////////////////////////////////////////

`define REG_CTRL 16'h0000
`define REG_STATUS 16'h0004
`define REG_SMAP 16'h0008
`define REG_DATA 16'h0020
`define OUT_BASE 16'h1000

`endif

/* hdl/chunk_pkg.sv */
`include "chunk_settings.svh"

package chunk_pkg;

	// One dense or nonzero byte
	typedef logic [7:0] byte_t;
	// Wishbone data word
	typedef logic [31:0] word_t;
	// Wishbone byte address
	typedef logic [15:0] wb_addr_t;

	// Whole sparsemap, one bit per dense byte
	typedef logic [`CHUNK_BYTES-1:0] smap_t;
	// Slice of the sparsemap read per step
	typedef logic [`PREFIX_GROUP-1:0] group_t;

	typedef logic [$clog2(`BEAT_NUM)-1:0] beat_idx_t;
	typedef logic [$clog2(`GROUP_NUM)-1:0] group_idx_t;
	// Dense position 0 to CHUNK_BYTES-1
	typedef logic [$clog2(`CHUNK_BYTES)-1:0] pos_t;
	// 0 means no nonzero byte seen yet, 1..CHUNK_BYTES index the array
	typedef logic [$clog2(`CHUNK_BYTES):0] rank_t;

	// Expander FSM
	typedef enum logic [1:0] {
		EXP_IDLE,
		EXP_RUN,
		EXP_FLUSH
	} exp_state_t;

endpackage

/* hdl/wb_chunk_loader.sv */
`timescale 1ns/1ps
`include "chunk_settings.svh"

module wb_chunk_loader (
	input  logic                                    clk_i,
	input  logic                                    rst_i,
	input  logic                                    wbs_cyc_i,
	input  logic                                    wbs_stb_i,
	input  logic                                    wbs_we_i,
	input  chunk_pkg::wb_addr_t                     wbs_adr_i,
	input  chunk_pkg::word_t                        wbs_dat_i,
	input  logic                                    busy_i,
	input  logic                                    done_i,
	output chunk_pkg::word_t                        wbs_dat_o,
	output logic                                    wbs_ack_o,
	output logic                                    wr_valid_o,
	output chunk_pkg::beat_idx_t                    wr_count_o,
	output logic [`BUS_BYTES-1:0]                   wr_sparsemap_o,
	output chunk_pkg::byte_t [`BUS_BYTES-1:0]       wr_nonzero_data_o,
	output logic                                    start_o
);

	// Byte offset bits inside one bus word
	localparam int LANE_W = $clog2(`BUS_BYTES);
	localparam int BEAT_W = $bits(chunk_pkg::beat_idx_t);

	logic                 req;
	logic                 wr_req;
	logic                 is_data;
	chunk_pkg::wb_addr_t  data_off;
	chunk_pkg::smap_t     smap_r;

	//////////////////////////////////////////////////////////////////////
	// Address decode
	//////////////////////////////////////////////////////////////////////

	// New access, ack low so not already answered
	assign req = wbs_cyc_i && wbs_stb_i && !wbs_ack_o;
	assign wr_req = req && wbs_we_i;

	// Offset into the data window, one beat per word
	assign data_off = wbs_adr_i - chunk_pkg::wb_addr_t'(`REG_DATA);
	assign is_data = (wbs_adr_i >= chunk_pkg::wb_addr_t'(`REG_DATA)) &&
		(data_off < chunk_pkg::wb_addr_t'(`BEAT_NUM * `BUS_BYTES));

	//////////////////////////////////////////////////////////////////////
	// Control state
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			wbs_ack_o <= 1'b0;
			wr_valid_o <= 1'b0;
			start_o <= 1'b0;
		end else begin
			// Single cycle ack, one cycle after the request
			wbs_ack_o <= req;
			// Beat write goes out alongside the ack
			wr_valid_o <= wr_req && is_data;
			// Start is a one cycle pulse
			start_o <= wr_req && (wbs_adr_i == `REG_CTRL) && wbs_dat_i[0];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Payload capture
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		// Staged sparsemap, sliced per beat later
		if (wr_req && (wbs_adr_i == `REG_SMAP)) begin
			smap_r <= wbs_dat_i;
		end
		// Beat index and lanes, lane 0 is the lowest nonzero index
		if (wr_req && is_data) begin
			wr_count_o <= data_off[LANE_W +: BEAT_W];
			wr_nonzero_data_o <= wbs_dat_i;
		end
		// Read data, only status has content
		if (req && !wbs_we_i) begin
			if (wbs_adr_i == `REG_STATUS) begin
				wbs_dat_o <= chunk_pkg::word_t'({done_i, busy_i});
			end else begin
				wbs_dat_o <= '0;
			end
		end
	end

	// Sparsemap bits that belong to the current beat
	assign wr_sparsemap_o = smap_r[wr_count_o * `BUS_BYTES +: `BUS_BYTES];

	// Every ack answers a live request from the cycle before
	a_ack_needs_req : assert property (@(posedge clk_i) disable iff (rst_i)
		$rose(wbs_ack_o) |-> $past(wbs_cyc_i && wbs_stb_i));

endmodule

/* hdl/data_chunk.sv */
`timescale 1ns/1ps
`include "chunk_settings.svh"

module data_chunk (
	input  logic                                clk_i,
	input  logic                                rst_i,
	input  logic                                wr_valid_i,
	input  chunk_pkg::beat_idx_t                wr_count_i,
	input  logic [`BUS_BYTES-1:0]               wr_sparsemap_i,
	input  chunk_pkg::byte_t [`BUS_BYTES-1:0]   wr_nonzero_data_i,
	input  chunk_pkg::group_idx_t               rd_group_i,
	input  chunk_pkg::rank_t                    rd_addr_i,
	output chunk_pkg::group_t                   rd_sparsemap_o,
	output chunk_pkg::byte_t                    rd_data_o
);

	chunk_pkg::smap_t mem_sparsemap_r;
	// Nonzero array is 1-based, rank 0 has no entry
	chunk_pkg::byte_t [`CHUNK_BYTES:1] mem_nonzero_r;

	//////////////////////////////////////////////////////////////////////
	// Beat write port
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			mem_sparsemap_r <= '0;
			mem_nonzero_r <= '0;
		end else if (wr_valid_i) begin
			// Beat i fills sparsemap bits 4i.. and nonzero slots 4i+1..
			for (int i = 0; i < `BEAT_NUM; i++) begin
				if (wr_count_i == chunk_pkg::beat_idx_t'(i)) begin
					mem_sparsemap_r[`BUS_BYTES*i +: `BUS_BYTES] <= wr_sparsemap_i;
					mem_nonzero_r[(`BUS_BYTES*i + 1) +: `BUS_BYTES] <= wr_nonzero_data_i;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Combinational reads
	//////////////////////////////////////////////////////////////////////

	// Group read for the expander
	assign rd_sparsemap_o = mem_sparsemap_r[rd_group_i * `PREFIX_GROUP +: `PREFIX_GROUP];

	// Rank read, out of range ranks give zero
	always_comb begin
		rd_data_o = '0;
		if ((rd_addr_i != '0) && (rd_addr_i <= chunk_pkg::rank_t'(`CHUNK_BYTES))) begin
			rd_data_o = mem_nonzero_r[rd_addr_i];
		end
	end

	// Loader must always present a defined beat with its write
	a_wr_count_known : assert property (@(posedge clk_i) disable iff (rst_i)
		wr_valid_i |-> !$isunknown(wr_count_i));

endmodule

/* hdl/sparse_expander.sv */
`timescale 1ns/1ps
`include "chunk_settings.svh"

module sparse_expander (
	input  logic                    clk_i,
	input  logic                    rst_i,
	input  logic                    start_i,
	input  chunk_pkg::group_t       rd_sparsemap_i,
	input  chunk_pkg::byte_t        rd_data_i,
	input  logic                    byte_ready_i,
	input  logic                    last_ack_i,
	output chunk_pkg::group_idx_t   rd_group_o,
	output chunk_pkg::rank_t        rd_addr_o,
	output logic                    byte_valid_o,
	output chunk_pkg::byte_t        byte_data_o,
	output logic                    busy_o,
	output logic                    done_o
);

	localparam int POS_W = $bits(chunk_pkg::pos_t);
	localparam int GRP_W = $bits(chunk_pkg::group_idx_t);
	// Bits of the position that pick a bit inside a group
	localparam int BIT_W = $clog2(`PREFIX_GROUP);

	chunk_pkg::exp_state_t  state_r;
	chunk_pkg::pos_t        pos_r;
	chunk_pkg::rank_t       rank_r;
	chunk_pkg::rank_t       rank_next;
	logic                   bit_set;
	logic                   xfer;
	logic                   last_pos;

	//////////////////////////////////////////////////////////////////////
	// Prefix rank datapath
	//////////////////////////////////////////////////////////////////////

	// Upper position bits select the group
	assign rd_group_o = pos_r[POS_W-1 -: GRP_W];
	assign bit_set = rd_sparsemap_i[pos_r[BIT_W-1:0]];

	// Set bit bumps the running count, 1-based
	assign rank_next = bit_set ? rank_r + chunk_pkg::rank_t'(1) : rank_r;
	// Byte read at the already incremented rank
	assign rd_addr_o = rank_next;
	assign byte_data_o = bit_set ? rd_data_i : '0;

	assign byte_valid_o = (state_r == chunk_pkg::EXP_RUN);
	assign xfer = byte_valid_o && byte_ready_i;
	assign last_pos = (pos_r == chunk_pkg::pos_t'(`CHUNK_BYTES - 1));

	assign busy_o = (state_r != chunk_pkg::EXP_IDLE);

	//////////////////////////////////////////////////////////////////////
	// FSM
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_r <= chunk_pkg::EXP_IDLE;
			pos_r <= '0;
			rank_r <= '0;
			done_o <= 1'b0;
		end else begin
			case (state_r)
				chunk_pkg::EXP_IDLE: begin
					// Fresh run, start ignored otherwise
					if (start_i) begin
						pos_r <= '0;
						rank_r <= '0;
						done_o <= 1'b0;
						state_r <= chunk_pkg::EXP_RUN;
					end
				end
				chunk_pkg::EXP_RUN: begin
					// One dense position per accepted byte
					if (xfer) begin
						pos_r <= pos_r + chunk_pkg::pos_t'(1);
						rank_r <= rank_next;
						if (last_pos) begin
							state_r <= chunk_pkg::EXP_FLUSH;
						end
					end
				end
				chunk_pkg::EXP_FLUSH: begin
					// Wait until the sink took the final word
					if (last_ack_i) begin
						done_o <= 1'b1;
						state_r <= chunk_pkg::EXP_IDLE;
					end
				end
				default: begin
					state_r <= chunk_pkg::EXP_IDLE;
				end
			endcase
		end
	end

	// Rank stays inside the nonzero array across the whole run
	a_rank_bound : assert property (@(posedge clk_i) disable iff (rst_i)
		rank_r <= chunk_pkg::rank_t'(`CHUNK_BYTES));

endmodule

/* hdl/wb_dense_writer.sv */
`timescale 1ns/1ps
`include "chunk_settings.svh"

module wb_dense_writer (
	input  logic                    clk_i,
	input  logic                    rst_i,
	input  logic                    byte_valid_i,
	input  chunk_pkg::byte_t        byte_data_i,
	input  logic                    wbm_ack_i,
	output logic                    byte_ready_o,
	output logic                    wbm_cyc_o,
	output logic                    wbm_stb_o,
	output logic                    wbm_we_o,
	output chunk_pkg::wb_addr_t     wbm_adr_o,
	output chunk_pkg::word_t        wbm_dat_o,
	output logic                    last_ack_o
);

	localparam int LANE_W = $clog2(`BUS_BYTES);
	localparam int WORD_W = $bits(chunk_pkg::word_t);

	logic [LANE_W-1:0]      lane_cnt_r;
	chunk_pkg::beat_idx_t   word_cnt_r;
	chunk_pkg::word_t       lanes_r;
	logic                   req_r;
	logic                   xfer;
	logic                   acked;

	// Back-pressure while a word is on the bus
	assign byte_ready_o = !req_r;
	assign xfer = byte_valid_i && byte_ready_o;
	assign acked = req_r && wbm_ack_i;

	//////////////////////////////////////////////////////////////////////
	// Lane packing
	//////////////////////////////////////////////////////////////////////

	// Bytes enter at the top and shift down, first byte ends in lane 0
	always_ff @(posedge clk_i) begin
		if (xfer) begin
			lanes_r <= {byte_data_i, lanes_r[WORD_W-1:8]};
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Master request
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			lane_cnt_r <= '0;
			word_cnt_r <= '0;
			req_r <= 1'b0;
		end else begin
			if (xfer) begin
				lane_cnt_r <= lane_cnt_r + 1'b1;
				// Fourth byte opens the bus cycle
				if (lane_cnt_r == '1) begin
					req_r <= 1'b1;
				end
			end
			// Request ends the cycle after ack, word counter wraps per chunk
			if (acked) begin
				req_r <= 1'b0;
				word_cnt_r <= word_cnt_r + 1'b1;
			end
		end
	end

	assign wbm_cyc_o = req_r;
	assign wbm_stb_o = req_r;
	assign wbm_we_o = req_r;
	// Word k lands at OUT_BASE + 4k
	assign wbm_adr_o = chunk_pkg::wb_addr_t'(`OUT_BASE) +
		chunk_pkg::wb_addr_t'({word_cnt_r, {LANE_W{1'b0}}});
	assign wbm_dat_o = lanes_r;

	// Ack of the final word of the chunk
	assign last_ack_o = acked && (word_cnt_r == chunk_pkg::beat_idx_t'(`BEAT_NUM - 1));

	// Classic cycle held steady while the sink stalls
	a_req_stable : assert property (@(posedge clk_i) disable iff (rst_i)
		(wbm_stb_o && !wbm_ack_i) |=>
			(wbm_stb_o && $stable(wbm_adr_o) && $stable(wbm_dat_o)));

endmodule

/* hdl/sparse_decomp_top.sv */
`timescale 1ns/1ps
`include "chunk_settings.svh"

module sparse_decomp_top (
	input  logic                    clk_i,
	input  logic                    rst_i,
	// Host slave port
	input  logic                    wbs_cyc_i,
	input  logic                    wbs_stb_i,
	input  logic                    wbs_we_i,
	input  chunk_pkg::wb_addr_t     wbs_adr_i,
	input  chunk_pkg::word_t        wbs_dat_i,
	output chunk_pkg::word_t        wbs_dat_o,
	output logic                    wbs_ack_o,
	// Sink master port
	output logic                    wbm_cyc_o,
	output logic                    wbm_stb_o,
	output logic                    wbm_we_o,
	output chunk_pkg::wb_addr_t     wbm_adr_o,
	output chunk_pkg::word_t        wbm_dat_o,
	input  logic                    wbm_ack_i
);

	//////////////////////////////////////////////////////////////////////
	// Internal nets
	//////////////////////////////////////////////////////////////////////

	// Loader to store
	logic                               wr_valid;
	chunk_pkg::beat_idx_t               wr_count;
	logic [`BUS_BYTES-1:0]              wr_sparsemap;
	chunk_pkg::byte_t [`BUS_BYTES-1:0]  wr_nonzero_data;
	logic                               start;

	// Store and expander
	chunk_pkg::group_idx_t              rd_group;
	chunk_pkg::rank_t                   rd_addr;
	chunk_pkg::group_t                  rd_sparsemap;
	chunk_pkg::byte_t                   rd_data;

	// Expander and writer
	logic                               byte_valid;
	logic                               byte_ready;
	chunk_pkg::byte_t                   byte_data;
	logic                               last_ack;

	// Status back to host
	logic                               busy;
	logic                               done;

	//////////////////////////////////////////////////////////////////////
	// Blocks
	//////////////////////////////////////////////////////////////////////

	wb_chunk_loader i_loader (
		.clk_i             (clk_i),
		.rst_i             (rst_i),
		.wbs_cyc_i         (wbs_cyc_i),
		.wbs_stb_i         (wbs_stb_i),
		.wbs_we_i          (wbs_we_i),
		.wbs_adr_i         (wbs_adr_i),
		.wbs_dat_i         (wbs_dat_i),
		.busy_i            (busy),
		.done_i            (done),
		.wbs_dat_o         (wbs_dat_o),
		.wbs_ack_o         (wbs_ack_o),
		.wr_valid_o        (wr_valid),
		.wr_count_o        (wr_count),
		.wr_sparsemap_o    (wr_sparsemap),
		.wr_nonzero_data_o (wr_nonzero_data),
		.start_o           (start)
	);

	data_chunk i_chunk (
		.clk_i             (clk_i),
		.rst_i             (rst_i),
		.wr_valid_i        (wr_valid),
		.wr_count_i        (wr_count),
		.wr_sparsemap_i    (wr_sparsemap),
		.wr_nonzero_data_i (wr_nonzero_data),
		.rd_group_i        (rd_group),
		.rd_addr_i         (rd_addr),
		.rd_sparsemap_o    (rd_sparsemap),
		.rd_data_o         (rd_data)
	);

	sparse_expander i_expander (
		.clk_i          (clk_i),
		.rst_i          (rst_i),
		.start_i        (start),
		.rd_sparsemap_i (rd_sparsemap),
		.rd_data_i      (rd_data),
		.byte_ready_i   (byte_ready),
		.last_ack_i     (last_ack),
		.rd_group_o     (rd_group),
		.rd_addr_o      (rd_addr),
		.byte_valid_o   (byte_valid),
		.byte_data_o    (byte_data),
		.busy_o         (busy),
		.done_o         (done)
	);

	wb_dense_writer i_writer (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.byte_valid_i (byte_valid),
		.byte_data_i  (byte_data),
		.wbm_ack_i    (wbm_ack_i),
		.byte_ready_o (byte_ready),
		.wbm_cyc_o    (wbm_cyc_o),
		.wbm_stb_o    (wbm_stb_o),
		.wbm_we_o     (wbm_we_o),
		.wbm_adr_o    (wbm_adr_o),
		.wbm_dat_o    (wbm_dat_o),
		.last_ack_o   (last_ack)
	);

endmodule

/* verif/tb_sparse_decomp.sv */
`timescale 1ns/1ps
`include "chunk_settings.svh"

module tb_sparse_decomp;

	// Dense output words per chunk
	localparam int WORDS = `CHUNK_BYTES / 4;
	// One run of bytes at up to 4 cycles each plus loads and status polls
	localparam int RUN_CYCLES = `CHUNK_BYTES * 4 + 4 * (`BEAT_NUM + 8);
	// Nine tests with a wide margin
	localparam int MAX_CYCLES = 9 * RUN_CYCLES * 11;

	logic                 clk_i;
	logic                 rst_i;
	logic                 wbs_cyc_i;
	logic                 wbs_stb_i;
	logic                 wbs_we_i;
	chunk_pkg::wb_addr_t  wbs_adr_i;
	chunk_pkg::word_t     wbs_dat_i;
	chunk_pkg::word_t     wbs_dat_o;
	logic                 wbs_ack_o;
	logic                 wbm_cyc_o;
	logic                 wbm_stb_o;
	logic                 wbm_we_o;
	chunk_pkg::wb_addr_t  wbm_adr_o;
	chunk_pkg::word_t     wbm_dat_o;
	logic                 wbm_ack_i;

	int errors;
	int checks;
	int test_num;
	int sink_writes;
	int cycles;
	logic [31:0] rng_state;

	// Sink records and expected words in arrival order
	chunk_pkg::wb_addr_t got_adr_q[$];
	chunk_pkg::word_t    got_dat_q[$];
	chunk_pkg::wb_addr_t exp_adr_q[$];
	chunk_pkg::word_t    exp_dat_q[$];

	sparse_decomp_top i_dut (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.wbs_cyc_i (wbs_cyc_i),
		.wbs_stb_i (wbs_stb_i),
		.wbs_we_i  (wbs_we_i),
		.wbs_adr_i (wbs_adr_i),
		.wbs_dat_i (wbs_dat_i),
		.wbs_dat_o (wbs_dat_o),
		.wbs_ack_o (wbs_ack_o),
		.wbm_cyc_o (wbm_cyc_o),
		.wbm_stb_o (wbm_stb_o),
		.wbm_we_o  (wbm_we_o),
		.wbm_adr_o (wbm_adr_o),
		.wbm_dat_o (wbm_dat_o),
		.wbm_ack_i (wbm_ack_i)
	);

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Word k of the dense chunk with the rank counted 1-based over bits 0..j
	function automatic chunk_pkg::word_t decode_word(input chunk_pkg::smap_t smap,
		input logic [8*`CHUNK_BYTES-1:0] nz, input int k);
		chunk_pkg::word_t w;
		int rank;
		w = '0;
		rank = 0;
		for (int j = 0; j < 4 * k + 4; j++) begin
			if (smap[j]) begin
				rank++;
				if (j >= 4 * k) begin
					w[8*(j-4*k) +: 8] = nz[8*(rank-1) +: 8];
				end
			end
		end
		return w;
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp_v,
		input logic [31:0] got_v);
		checks++;
		if (got_v !== exp_v) begin
			$display("[ERROR] %0t ns %s expected %h got %h", $time, name, exp_v, got_v);
			errors++;
		end
	endtask

	task automatic wb_write(input chunk_pkg::wb_addr_t adr, input chunk_pkg::word_t dat);
		@(posedge clk_i);
		#1;
		wbs_cyc_i = 1'b1;
		wbs_stb_i = 1'b1;
		wbs_we_i = 1'b1;
		wbs_adr_i = adr;
		wbs_dat_i = dat;
		do begin
			@(posedge clk_i);
			#1;
		end while (!wbs_ack_o);
		wbs_cyc_i = 1'b0;
		wbs_stb_i = 1'b0;
		wbs_we_i = 1'b0;
	endtask

	task automatic wb_read(input chunk_pkg::wb_addr_t adr, output chunk_pkg::word_t dat);
		@(posedge clk_i);
		#1;
		wbs_cyc_i = 1'b1;
		wbs_stb_i = 1'b1;
		wbs_we_i = 1'b0;
		wbs_adr_i = adr;
		do begin
			@(posedge clk_i);
			#1;
		end while (!wbs_ack_o);
		// Read data registered together with ack
		dat = wbs_dat_o;
		wbs_cyc_i = 1'b0;
		wbs_stb_i = 1'b0;
	endtask

	// Sparsemap goes first since data beats slice it
	task automatic load_chunk(input chunk_pkg::smap_t smap, input logic [8*`CHUNK_BYTES-1:0] nz);
		wb_write(`REG_SMAP, smap);
		for (int i = 0; i < `BEAT_NUM; i++) begin
			wb_write(chunk_pkg::wb_addr_t'(`REG_DATA + 4 * i), nz[32*i +: 32]);
		end
	endtask

	task automatic expect_chunk(input chunk_pkg::smap_t smap,
		input logic [8*`CHUNK_BYTES-1:0] nz);
		for (int k = 0; k < WORDS; k++) begin
			exp_adr_q.push_back(chunk_pkg::wb_addr_t'(`OUT_BASE + 4 * k));
			exp_dat_q.push_back(decode_word(smap, nz, k));
		end
	endtask

	// Load, start, watch status, then count the sink writes
	task automatic run_chunk(input string name, input chunk_pkg::smap_t smap,
		input logic [8*`CHUNK_BYTES-1:0] nz, input bit second_start);
		chunk_pkg::word_t status;
		int err_before;
		int writes_before;
		err_before = errors;
		test_num++;
		load_chunk(smap, nz);
		expect_chunk(smap, nz);
		writes_before = sink_writes;
		wb_write(`REG_CTRL, 32'h1);
		wb_read(`REG_STATUS, status);
		check_val("status_busy", 1, status[0]);
		check_val("status_done", 0, status[1]);
		if (second_start) begin
			wb_write(`REG_CTRL, 32'h1);
		end
		// Poll until done
		status = '0;
		while (!status[1]) begin
			wb_read(`REG_STATUS, status);
		end
		check_val("status_busy", 0, status[0]);
		repeat (2) @(negedge clk_i);
		if (second_start) begin
			// A latched restart would show up here as more writes
			repeat (40) @(posedge clk_i);
			wb_read(`REG_STATUS, status);
			check_val("status_busy", 0, status[0]);
		end
		check_val("sink_writes", WORDS, sink_writes - writes_before);
		exp_adr_q.delete();
		exp_dat_q.delete();
		$display("Test %0d %s: %s", test_num, name, (errors == err_before) ? "ok" : "FAILED");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Clock, timeout, sink and compare
	//////////////////////////////////////////////////////////////////////

	initial begin
		clk_i = 1'b0;
		forever #4 clk_i = ~clk_i;
	end

	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge clk_i);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
		$display("Test failures found");
		$finish;
	end

	// Sink acks after a random 0 to 3 cycle stall
	initial begin
		int stall;
		bit pending;
		wbm_ack_i = 1'b0;
		pending = 1'b0;
		stall = 0;
		forever begin
			@(posedge clk_i);
			#1;
			if (wbm_ack_i) begin
				wbm_ack_i = 1'b0;
				pending = 1'b0;
			end else if (wbm_cyc_o && wbm_stb_o) begin
				if (!pending) begin
					pending = 1'b1;
					rng_state = xorshift32(rng_state);
					stall = int'(rng_state[1:0]);
				end
				if (stall == 0) begin
					// Every sink cycle must be a write
					check_val("wbm_we_o", 1, wbm_we_o);
					wbm_ack_i = 1'b1;
					sink_writes++;
					got_adr_q.push_back(wbm_adr_o);
					got_dat_q.push_back(wbm_dat_o);
				end else begin
					stall--;
				end
			end
		end
	end

	initial begin
		chunk_pkg::wb_addr_t adr;
		chunk_pkg::word_t dat;
		forever begin
			@(negedge clk_i);
			while (got_adr_q.size() > 0) begin
				adr = got_adr_q.pop_front();
				dat = got_dat_q.pop_front();
				if (exp_adr_q.size() == 0) begin
					$display("Sink write to %h arrived when no word was expected", adr);
					errors++;
				end else begin
					check_val("wbm_adr_o", exp_adr_q.pop_front(), adr);
					check_val("wbm_dat_o", exp_dat_q.pop_front(), dat);
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		chunk_pkg::word_t status;
		chunk_pkg::smap_t smap;
		logic [8*`CHUNK_BYTES-1:0] nz;
		errors = 0;
		checks = 0;
		test_num = 0;
		sink_writes = 0;
		rng_state = 32'h49405068;
		rst_i = 1'b1;
		wbs_cyc_i = 1'b0;
		wbs_stb_i = 1'b0;
		wbs_we_i = 1'b0;
		wbs_adr_i = '0;
		wbs_dat_i = '0;
		repeat (2) @(posedge clk_i);
		#1;
		rst_i = 1'b0;

		// Idle state after reset
		test_num++;
		check_val("wbm_cyc_o", 0, wbm_cyc_o);
		check_val("wbm_stb_o", 0, wbm_stb_o);
		wb_read(`REG_STATUS, status);
		check_val("wbs_dat_o", 0, status);
		$display("Test %0d reset: %s", test_num, (errors == 0) ? "ok" : "FAILED");

		// Known data so the sparsemap decides everything
		for (int i = 0; i < `CHUNK_BYTES; i++) begin
			nz[8*i +: 8] = 8'(i + 8'h41);
		end
		run_chunk("zero sparsemap", '0, nz, 1'b0);
		run_chunk("full sparsemap", '1, nz, 1'b0);

		// Random chunks under random sink stalls
		for (int t = 0; t < 5; t++) begin
			rng_state = xorshift32(rng_state);
			smap = rng_state;
			for (int i = 0; i < `BEAT_NUM; i++) begin
				rng_state = xorshift32(rng_state);
				nz[32*i +: 32] = rng_state;
			end
			run_chunk($sformatf("random chunk %0d", t), smap, nz, 1'b0);
		end

		// Restart request while busy
		rng_state = xorshift32(rng_state);
		smap = rng_state;
		run_chunk("second start", smap, nz, 1'b1);

		$display("Tests: %0d, checks: %0d, errors: %0d", test_num, checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

/* all.f */
+incdir+hdl
hdl/chunk_pkg.sv
hdl/wb_chunk_loader.sv
hdl/data_chunk.sv
hdl/sparse_expander.sv
hdl/wb_dense_writer.sv
hdl/sparse_decomp_top.sv
verif/tb_sparse_decomp.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_sparse_decomp
FILELIST  := all.f
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -j 0
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
